/* verilog.f */
+incdir+test
hw/scratchpad_pkg.sv
hw/sp_fifo.sv
hw/sp_request_decode.sv
hw/sp_mat_array.sv
hw/sp_result_route.sv
hw/scratchpad_bank.sv
test/tb_scratchpad_bank.sv

/* test/tb_scratchpad_checks.svh */
`ifndef TB_SCRATCHPAD_CHECKS_SVH
`define TB_SCRATCHPAD_CHECKS_SVH

task automatic check_dram(input logic [DRAM_OUT_W-1:0] got, input logic [DRAM_OUT_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("ERROR at %0t: %s dram entry got %h expected %h", $time, what, got, exp);
        fail_run("stopping at the first mismatch");
    end
endtask

task automatic check_gemm(input logic [GEMM_OUT_W-1:0] got, input logic [GEMM_OUT_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("ERROR at %0t: %s gemm entry got %h expected %h", $time, what, got, exp);
        fail_run("stopping at the first mismatch");
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
        fail_run("stopping at the first mismatch");
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
        fail_run("stopping at the first mismatch");
    end
endtask

// compares the head with the oldest expected entry, then pops it
task automatic pop_dram(input string what);
    int                    waited;
    logic [DRAM_OUT_W-1:0] expected;
    waited = 0;
    while (dram_empty && waited < WAIT_LIMIT) begin
        tick();
        waited++;
    end
    if (dram_empty) fail_run("DRAM output queue stayed empty while an entry was due");
    expected = exp_dram.pop_front();
    check_dram(dram_rdata, expected, what);
    dram_ren = 1'b1;
    tick();
    dram_ren = 1'b0;
endtask

task automatic pop_gemm(input string what);
    int                    waited;
    logic [GEMM_OUT_W-1:0] expected;
    waited = 0;
    while (gemm_empty && waited < WAIT_LIMIT) begin
        tick();
        waited++;
    end
    if (gemm_empty) fail_run("GEMM output queue stayed empty while an entry was due");
    expected = exp_gemm.pop_front();
    check_gemm(gemm_rdata, expected, what);
    gemm_ren = 1'b1;
    tick();
    gemm_ren = 1'b0;
endtask

`endif

/* test/tb_scratchpad_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scratchpad_bank;

    import scratchpad_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          DRIVE_DELAY = 2;
    localparam int          TEST_CYCLES = 400;  // upper bound on the whole directed sequence
    localparam int          WAIT_LIMIT  = 50;   // cycles any single handshake may take
    localparam logic [31:0] SEED        = 32'h3daa9709;

    logic                  CLK;
    logic                  nRST;
    logic                  w_wen;
    logic [W_ENTRY_W-1:0]  w_wdata;
    logic                  w_full;
    logic                  r_wen;
    logic [RD_REQ_W-1:0]   r_wdata;
    logic                  r_full;
    logic                  dram_ren;
    logic [DRAM_OUT_W-1:0] dram_rdata;
    logic                  dram_empty;
    logic                  gemm_ren;
    logic [GEMM_OUT_W-1:0] gemm_rdata;
    logic                  gemm_empty;
    logic                  gemm_complete;

    logic [BITS_PER_ROW-1:0] model [16];  // indexed by {mat, row}
    logic [DRAM_OUT_W-1:0]   exp_dram [$];
    logic [GEMM_OUT_W-1:0]   exp_gemm [$];
    logic [31:0]             lfsr_state;
    int                      pulse_cycles;
    int                      pulse_rises;
    logic                    complete_prev;

    scratchpad_bank i_scratchpad_bank (
        .CLK(CLK), .nRST(nRST),
        .w_wen(w_wen), .w_wdata(w_wdata), .w_full(w_full),
        .r_wen(r_wen), .r_wdata(r_wdata), .r_full(r_full),
        .dram_ren(dram_ren), .dram_rdata(dram_rdata), .dram_empty(dram_empty),
        .gemm_ren(gemm_ren), .gemm_rdata(gemm_rdata), .gemm_empty(gemm_empty),
        .gemm_complete(gemm_complete)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // sampled mid-cycle, well away from the edge that updates it
    always @(negedge CLK) begin
        if (gemm_complete) pulse_cycles++;
        if (gemm_complete && !complete_prev) pulse_rises++;
        complete_prev = gemm_complete;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic tick();
        @(posedge CLK);
        #(DRIVE_DELAY);  // inputs change just after the edge
    endtask

    // fibonacci lfsr with taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[62:0], fb};
        end
        return bits;
    endfunction

    `include "tb_scratchpad_checks.svh"

    task automatic push_write(input logic [MAT_S_W-1:0] mat, input logic [ROW_S_W-1:0] row,
                              input logic [BITS_PER_ROW-1:0] data, input logic done);
        int waited;
        waited = 0;
        while (w_full && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (w_full) fail_run("write queue stayed full");
        w_wdata = {done, mat, row, data};
        w_wen = 1'b1;
        model[{mat, row}] = data;
        tick();
        w_wen = 1'b0;
    endtask

    // a zero kind is a store to dram, anything else a gemm read of that type
    task automatic push_read(input logic [MTYPE_W-1:0] kind, input logic [WORD_W-1:0] addr,
                             input logic [MAT_S_W-1:0] mat, input logic [ROW_S_W-1:0] row);
        int waited;
        waited = 0;
        while (r_full && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (r_full) fail_run("read queue stayed full");
        r_wdata = {addr, kind, mat, row};
        r_wen = 1'b1;
        if (kind == 2'b00) exp_dram.push_back({addr, mat, row, model[{mat, row}]});
        else exp_gemm.push_back({kind, mat, row, model[{mat, row}]});
        tick();
        r_wen = 1'b0;
    endtask

    task automatic issue_random_read(input logic gemm);
        logic [3:0]         loc;
        logic [WORD_W-1:0]  addr;
        logic [MTYPE_W-1:0] kind;
        loc = 4'(rand_bits(4));
        addr = 32'(rand_bits(32));  // the gemm view ignores these bits
        kind = 2'b00;
        if (gemm) begin
            kind = 2'(rand_bits(2));
            if (kind == 2'b00) kind = 2'b01;
        end
        push_read(kind, addr, loc[3:2], loc[1:0]);
    endtask

    task automatic wait_complete();
        int waited;
        waited = 0;
        while (!gemm_complete && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (!gemm_complete) fail_run("gemm_complete never rose after a done-flagged write");
        tick();
    endtask

    task automatic drain_outputs(input string what);
        while (exp_gemm.size() > 0) pop_gemm(what);
        while (exp_dram.size() > 0) pop_dram(what);
        tick();
        check_bit(dram_empty, 1'b1, {what, " dram_empty after drain"});
        check_bit(gemm_empty, 1'b1, {what, " gemm_empty after drain"});
    endtask

    task automatic test_reset();
        check_bit(dram_empty, 1'b1, "dram_empty after reset");
        check_bit(gemm_empty, 1'b1, "gemm_empty after reset");
        check_bit(w_full, 1'b0, "w_full after reset");
        check_bit(r_full, 1'b0, "r_full after reset");
        check_bit(gemm_complete, 1'b0, "gemm_complete after reset");
        issue_random_read(1'b0);  // nothing written yet, so the row must read back as zero
        drain_outputs("storage after reset");
    endtask

    task automatic test_store_read();
        int i;
        for (i = 0; i < 16; i++) begin
            push_write(2'(i >> 2), 2'(i), rand_bits(64), i == 15);
        end
        wait_complete();
        for (i = 0; i < 8; i++) issue_random_read(1'b0);
        drain_outputs("store read");
    endtask

    task automatic test_gemm_read();
        int i;
        for (i = 0; i < 6; i++) issue_random_read(1'b1);
        while (exp_gemm.size() > 0) begin
            check_bit(dram_empty, 1'b1, "dram_empty during gemm reads");
            pop_gemm("gemm read");
        end
        for (i = 0; i < 10; i++) issue_random_read(rand_bits(1) == 1);
        drain_outputs("mixed read");
    endtask

    task automatic test_complete_pulse();
        int cycles0;
        int rises0;
        cycles0 = pulse_cycles;
        rises0 = pulse_rises;
        push_write(2'd0, 2'd0, rand_bits(64), 1'b0);
        push_write(2'd0, 2'd1, rand_bits(64), 1'b1);
        push_write(2'd0, 2'd2, rand_bits(64), 1'b0);
        push_write(2'd0, 2'd3, rand_bits(64), 1'b0);
        push_write(2'd1, 2'd0, rand_bits(64), 1'b1);
        repeat (4) tick();
        check_count(pulse_rises - rises0, 2, "gemm_complete pulses");
        check_count(pulse_cycles - cycles0, 2, "gemm_complete high cycles");
    endtask

    task automatic test_overwrite();
        logic [BITS_PER_ROW-1:0] first;
        first = rand_bits(64);
        push_write(2'd2, 2'd1, first, 1'b1);
        wait_complete();
        push_read(2'b00, 32'(rand_bits(32)), 2'd2, 2'd1);
        drain_outputs("first write");
        push_write(2'd2, 2'd1, ~first, 1'b1);  // every bit differs from the old row
        wait_complete();
        push_read(2'b00, 32'(rand_bits(32)), 2'd2, 2'd1);
        drain_outputs("overwrite");
    endtask

    task automatic test_back_pressure();
        int i;
        for (i = 0; i < 24; i++) issue_random_read(1'b0);
        tick();
        check_bit(r_full, 1'b1, "r_full behind a full DRAM queue");
        drain_outputs("back-pressure");
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        w_wen = 1'b0;
        w_wdata = '0;
        r_wen = 1'b0;
        r_wdata = '0;
        dram_ren = 1'b0;
        gemm_ren = 1'b0;
        lfsr_state = SEED;
        pulse_cycles = 0;
        pulse_rises = 0;
        complete_prev = 1'b0;
        for (int i = 0; i < 16; i++) model[i] = '0;
        repeat (2) @(posedge CLK);
        #(DRIVE_DELAY);
        nRST = 1'b1;
        tick();
        test_reset();
        test_store_read();
        test_gemm_read();
        test_complete_pulse();
        test_overwrite();
        test_back_pressure();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/scratchpad_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_bank (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  w_wen,
    input  logic [scratchpad_pkg::W_ENTRY_W-1:0]  w_wdata,
    output logic                                  w_full,
    input  logic                                  r_wen,
    input  logic [scratchpad_pkg::RD_REQ_W-1:0]   r_wdata,
    output logic                                  r_full,
    input  logic                                  dram_ren,
    output logic [scratchpad_pkg::DRAM_OUT_W-1:0] dram_rdata,
    output logic                                  dram_empty,
    input  logic                                  gemm_ren,
    output logic [scratchpad_pkg::GEMM_OUT_W-1:0] gemm_rdata,
    output logic                                  gemm_empty,
    output logic                                  gemm_complete
);

    import scratchpad_pkg::*;

    logic [W_ENTRY_W-1:0]    w_entry;
    logic                    w_empty;
    logic                    w_ren;
    logic [RD_REQ_W-1:0]     r_entry;
    logic                    r_empty;
    logic                    r_ren;

    logic                    wr_en;
    logic [MAT_S_W-1:0]      wr_mat;
    logic [ROW_S_W-1:0]      wr_row;
    logic [BITS_PER_ROW-1:0] wr_data;

    logic                    rd_valid;
    logic                    rd_store;
    logic                    rd_accept;
    logic [WORD_W-1:0]       rd_addr;
    logic [MTYPE_W-1:0]      rd_mtype;
    logic [MAT_S_W-1:0]      rd_mat;
    logic [ROW_S_W-1:0]      rd_row;
    logic [BITS_PER_ROW-1:0] rd_data;

    logic                    dram_wen;
    logic [DRAM_OUT_W-1:0]   dram_wdata;
    logic                    dram_full;
    logic                    gemm_wen;
    logic [GEMM_OUT_W-1:0]   gemm_wdata;
    logic                    gemm_full;

    // write requests from the systolic array side
    sp_fifo #(.WIDTH(W_ENTRY_W), .DEPTH(FIFO_DEPTH)) i_w_fifo (
        .CLK(CLK), .nRST(nRST), .wen(w_wen), .wdata(w_wdata), .ren(w_ren),
        .rdata(w_entry), .full(w_full), .empty(w_empty)
    );

    sp_fifo #(.WIDTH(RD_REQ_W), .DEPTH(FIFO_DEPTH)) i_r_fifo (
        .CLK(CLK), .nRST(nRST), .wen(r_wen), .wdata(r_wdata), .ren(r_ren),
        .rdata(r_entry), .full(r_full), .empty(r_empty)
    );

    sp_request_decode i_decode (
        .CLK(CLK), .nRST(nRST),
        .w_entry(w_entry), .w_empty(w_empty), .w_ren(w_ren),
        .wr_en(wr_en), .wr_mat(wr_mat), .wr_row(wr_row), .wr_data(wr_data),
        .gemm_complete(gemm_complete),
        .r_req(r_entry), .r_empty(r_empty), .r_ren(r_ren),
        .rd_valid(rd_valid), .rd_store(rd_store), .rd_addr(rd_addr), .rd_mtype(rd_mtype),
        .rd_mat(rd_mat), .rd_row(rd_row), .rd_accept(rd_accept)
    );

    sp_mat_array i_array (
        .CLK(CLK), .nRST(nRST),
        .wr_en(wr_en), .wr_mat(wr_mat), .wr_row(wr_row), .wr_data(wr_data),
        .rd_mat(rd_mat), .rd_row(rd_row), .rd_data(rd_data)
    );

    sp_result_route i_route (
        .rd_valid(rd_valid), .rd_store(rd_store), .rd_addr(rd_addr), .rd_mtype(rd_mtype),
        .rd_mat(rd_mat), .rd_row(rd_row), .rd_data(rd_data), .rd_accept(rd_accept),
        .dram_full(dram_full), .gemm_full(gemm_full),
        .dram_wen(dram_wen), .dram_wdata(dram_wdata),
        .gemm_wen(gemm_wen), .gemm_wdata(gemm_wdata)
    );

    // rows headed back to dram
    sp_fifo #(.WIDTH(DRAM_OUT_W), .DEPTH(FIFO_DEPTH)) i_dram_fifo (
        .CLK(CLK), .nRST(nRST), .wen(dram_wen), .wdata(dram_wdata), .ren(dram_ren),
        .rdata(dram_rdata), .full(dram_full), .empty(dram_empty)
    );

    // operand rows headed to the systolic array
    sp_fifo #(.WIDTH(GEMM_OUT_W), .DEPTH(FIFO_DEPTH)) i_gemm_fifo (
        .CLK(CLK), .nRST(nRST), .wen(gemm_wen), .wdata(gemm_wdata), .ren(gemm_ren),
        .rdata(gemm_rdata), .full(gemm_full), .empty(gemm_empty)
    );

endmodule

`default_nettype wire

/* hw/sp_result_route.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_result_route (
    input  logic                                    rd_valid,
    input  logic                                    rd_store,
    input  logic [scratchpad_pkg::WORD_W-1:0]       rd_addr,
    input  logic [scratchpad_pkg::MTYPE_W-1:0]      rd_mtype,
    input  logic [scratchpad_pkg::MAT_S_W-1:0]      rd_mat,
    input  logic [scratchpad_pkg::ROW_S_W-1:0]      rd_row,
    input  logic [scratchpad_pkg::BITS_PER_ROW-1:0] rd_data,
    output logic                                    rd_accept,
    input  logic                                    dram_full,
    input  logic                                    gemm_full,
    output logic                                    dram_wen,
    output logic [scratchpad_pkg::DRAM_OUT_W-1:0]   dram_wdata,
    output logic                                    gemm_wen,
    output logic [scratchpad_pkg::GEMM_OUT_W-1:0]   gemm_wdata
);

    logic dest_full;

    // a full destination holds the head, and every read behind it waits too
    assign dest_full = rd_store ? dram_full : gemm_full;
    assign rd_accept = rd_valid & ~dest_full;

    assign dram_wen = rd_accept & rd_store;
    assign gemm_wen = rd_accept & ~rd_store;

    // entries are built unconditionally, the write enables decide which one lands
    assign dram_wdata = {rd_addr, rd_mat, rd_row, rd_data};
    assign gemm_wdata = {rd_mtype, rd_mat, rd_row, rd_data};

endmodule

`default_nettype wire

/* hw/sp_mat_array.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_mat_array (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    wr_en,
    input  logic [scratchpad_pkg::MAT_S_W-1:0]      wr_mat,
    input  logic [scratchpad_pkg::ROW_S_W-1:0]      wr_row,
    input  logic [scratchpad_pkg::BITS_PER_ROW-1:0] wr_data,
    input  logic [scratchpad_pkg::MAT_S_W-1:0]      rd_mat,
    input  logic [scratchpad_pkg::ROW_S_W-1:0]      rd_row,
    output logic [scratchpad_pkg::BITS_PER_ROW-1:0] rd_data
);

    import scratchpad_pkg::*;

    localparam int NUM_MATS = 1 << MAT_S_W;
    localparam int NUM_ROWS = 1 << ROW_S_W;

    // each row is VALS_PER_ROW packed values of VALUE_BITS
    logic [NUM_MATS-1:0][NUM_ROWS-1:0][BITS_PER_ROW-1:0] mats;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mats <= '0;
        end else if (wr_en) begin
            mats[wr_mat][wr_row] <= wr_data;
        end
    end

    // read straight from the flops, a write shows up the cycle after it lands
    assign rd_data = mats[rd_mat][rd_row];

endmodule

`default_nettype wire

/* hw/sp_request_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_request_decode (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic [scratchpad_pkg::W_ENTRY_W-1:0] w_entry,
    input  logic                                 w_empty,
    output logic                                 w_ren,
    output logic                                 wr_en,
    output logic [scratchpad_pkg::MAT_S_W-1:0]   wr_mat,
    output logic [scratchpad_pkg::ROW_S_W-1:0]   wr_row,
    output logic [scratchpad_pkg::BITS_PER_ROW-1:0] wr_data,
    output logic                                 gemm_complete,
    input  scratchpad_pkg::rd_req_u              r_req,
    input  logic                                 r_empty,
    output logic                                 r_ren,
    output logic                                 rd_valid,
    output logic                                 rd_store,
    output logic [scratchpad_pkg::WORD_W-1:0]    rd_addr,
    output logic [scratchpad_pkg::MTYPE_W-1:0]   rd_mtype,
    output logic [scratchpad_pkg::MAT_S_W-1:0]   rd_mat,
    output logic [scratchpad_pkg::ROW_S_W-1:0]   rd_row,
    input  logic                                 rd_accept
);

    import scratchpad_pkg::*;

    logic w_done;

    // the array takes one row per cycle, so the write queue never stalls
    assign w_ren = ~w_empty;
    assign wr_en = ~w_empty;

    assign {w_done, wr_mat, wr_row, wr_data} = w_entry;

    // pulses the cycle after the last row of a gemm result lands
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gemm_complete <= 1'b0;
        end else begin
            gemm_complete <= wr_en & w_done;
        end
    end

    assign rd_valid = ~r_empty;
    assign rd_store = (r_req.store.kind == '0);  // zero kind means store
    assign rd_addr  = r_req.store.addr;
    assign rd_mtype = r_req.gemm.mtype;          // only meaningful for gemm reads
    assign rd_mat   = r_req.store.mat;           // selects sit in the same bits in both views
    assign rd_row   = r_req.store.row;

    // the head leaves the read queue only once routing has taken it
    assign r_ren = rd_accept;

endmodule

`default_nettype wire

/* hw/sp_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             wen,
    input  logic [WIDTH-1:0] wdata,
    input  logic             ren,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // requests that would overrun or underrun are dropped here
    assign do_write = wen & ~full;
    assign do_read  = ren & ~empty;

    assign rdata = mem[rd_ptr];  // head falls through, no read latency

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                // depth need not be a power of two, so wrap explicitly
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* hw/scratchpad_pkg.sv */
`default_nettype none

package scratchpad_pkg;

    // element and row geometry
    localparam int VALUE_BITS   = 16;
    localparam int VALS_PER_ROW = 4;
    localparam int BITS_PER_ROW = VALUE_BITS * VALS_PER_ROW;  // 64

    localparam int MAT_S_W = 2;   // four matrices
    localparam int ROW_S_W = 2;   // four rows per matrix
    localparam int MTYPE_W = 2;   // read kind or gemm matrix type
    localparam int WORD_W  = 32;  // dram address

    localparam int FIFO_DEPTH = 12;

    // {done, mat, row, data}
    localparam int W_ENTRY_W = 1 + MAT_S_W + ROW_S_W + BITS_PER_ROW;

    // {addr or unused, kind or mtype, mat, row}
    localparam int RD_REQ_W = WORD_W + MTYPE_W + MAT_S_W + ROW_S_W;

    // {addr, mat, row, data}
    localparam int DRAM_OUT_W = WORD_W + MAT_S_W + ROW_S_W + BITS_PER_ROW;

    // {mtype, mat, row, data}
    localparam int GEMM_OUT_W = MTYPE_W + MAT_S_W + ROW_S_W + BITS_PER_ROW;

    // a kind of zero marks a store, anything else is the gemm matrix type
    typedef union packed {
        struct packed {
            logic [WORD_W-1:0]  addr;
            logic [MTYPE_W-1:0] kind;
            logic [MAT_S_W-1:0] mat;
            logic [ROW_S_W-1:0] row;
        } store;
        struct packed {
            logic [WORD_W-1:0]  unused;
            logic [MTYPE_W-1:0] mtype;
            logic [MAT_S_W-1:0] mat;
            logic [ROW_S_W-1:0] row;
        } gemm;
    } rd_req_u;

endpackage

`default_nettype wire
